// File: hw/fpAddPkg.sv
package fpAddPkg;

	localparam int expWidth = 5;    // Exponent field
	localparam int manWidth = 10;   // Stored mantissa field
	localparam int dataWidth = 16;  // Full word
	localparam int expBias = 15;
	localparam int pipeDepth = 4;   // Stages from inValid to outValid

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} opT;

	typedef struct packed {
		logic                sign;
		logic [expWidth-1:0] exp;
		logic [manWidth-1:0] man;
	} fpT;

	// Stage 1 output, operands ordered by magnitude
	typedef struct packed {
		logic              signA;
		logic              signB;     // Already flipped for opSub
		opT                ctrl;      // Effective operation
		logic              maxAB;     // Set when b is larger
		logic [expWidth:0] bigExp;
		logic [manWidth:0] bigMan;    // Hidden bit included
		logic [manWidth:0] smallMan;  // Aligned to bigExp
		logic [2:0]        smallGrs;  // Guard, round, sticky
	} alignT;

	typedef struct packed {
		logic                zeroSum;
		logic                signA;
		logic                signB;
		opT                  ctrl;
		logic                maxAB;
		logic [expWidth:0]   bigExp;
		logic [manWidth+4:0] sumMan;  // Carry, 11 bits, G/R/S
	} sumT;

	typedef struct packed {
		logic                zeroSum;
		logic [expWidth:0]   normE;
		logic [manWidth-1:0] normM;
		logic                g;
		logic                r;
		logic                s;
		logic                signA;
		logic                signB;
		opT                  ctrl;
		logic                maxAB;
	} normT;

endpackage

// File: hw/fpAddAlign.sv
`timescale 1ns/100ps

module fpAddAlign (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,     // One-cycle operand strobe
	input  fpAddPkg::fpT     a,
	input  fpAddPkg::fpT     b,
	input  fpAddPkg::opT     op,
	output logic             alignValid,
	output fpAddPkg::alignT  align
);

	import fpAddPkg::*;

	logic                                signBEff;
	logic                                zeroA;
	logic                                zeroB;
	logic [manWidth:0]                   manA;
	logic [manWidth:0]                   manB;
	logic                                maxAB;
	logic [expWidth-1:0]                 bigExp;
	logic [expWidth-1:0]                 smallExp;
	logic [expWidth-1:0]                 expDiff;
	logic [manWidth:0]                   smallRaw;
	logic [manWidth + 2**expWidth - 1:0] shiftBuf;
	alignT                               alignNext;

	assign signBEff = b.sign ^ (op == opSub);       // Subtract flips b
	assign zeroA = (a.exp == '0);                   // Subnormal or zero
	assign zeroB = (b.exp == '0);
	assign manA = zeroA ? '0 : {1'b1, a.man};       // Hidden bit back in
	assign manB = zeroB ? '0 : {1'b1, b.man};

	// Exponent first, mantissa breaks the tie
	assign maxAB = {b.exp, manB} > {a.exp, manA};   // Equal keeps a on top

	assign bigExp = maxAB ? b.exp : a.exp;
	assign smallExp = maxAB ? a.exp : b.exp;
	assign smallRaw = maxAB ? manA : manB;
	assign expDiff = bigExp - smallExp;             // 0 to 31

	// Room below the mantissa for the widest shift
	assign shiftBuf = {smallRaw, {(2**expWidth - 1){1'b0}}} >> expDiff;

	always_comb begin
		alignNext.signA = a.sign;
		alignNext.signB = signBEff;
		alignNext.ctrl = (a.sign ^ signBEff) ? opSub : opAdd;  // Unlike signs subtract
		alignNext.maxAB = maxAB;
		alignNext.bigExp = {1'b0, bigExp};
		alignNext.bigMan = maxAB ? manB : manA;
		alignNext.smallMan = shiftBuf[$left(shiftBuf) -: manWidth + 1];
		alignNext.smallGrs[2] = shiftBuf[$left(shiftBuf) - manWidth - 1];  // Guard
		alignNext.smallGrs[1] = shiftBuf[$left(shiftBuf) - manWidth - 2];  // Round
		alignNext.smallGrs[0] = |shiftBuf[$left(shiftBuf) - manWidth - 3:0];  // Sticky
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			align <= alignNext;                     // Payload held when idle
		end
	end

	// Registered exponent never below the one that was shifted
	aBigExpOrder: assert property (@(posedge clk) disable iff (!rstN)
		inValid |=> align.bigExp >= {1'b0, $past(smallExp)})
		else $error("alignment picked the smaller exponent");

endmodule

// File: hw/fpAddMantSum.sv
`timescale 1ns/100ps

module fpAddMantSum (
	input  logic             clk,
	input  logic             rstN,
	input  logic             alignValid,
	input  fpAddPkg::alignT  align,
	output logic             sumValid,
	output fpAddPkg::sumT    sum
);

	import fpAddPkg::*;

	logic [manWidth+4:0] bigExt;
	logic [manWidth+4:0] smallExt;
	logic [manWidth+4:0] sumMan;
	sumT                 sumNext;

	assign bigExt = {1'b0, align.bigMan, 3'b000};              // Carry slot on top
	assign smallExt = {1'b0, align.smallMan, align.smallGrs};

	// Larger operand always on the left
	assign sumMan = (align.ctrl == opSub) ? bigExt - smallExt : bigExt + smallExt;

	always_comb begin
		sumNext.zeroSum = (sumMan == '0);                      // G/R/S count too
		sumNext.signA = align.signA;
		sumNext.signB = align.signB;
		sumNext.ctrl = align.ctrl;
		sumNext.maxAB = align.maxAB;
		sumNext.bigExp = align.bigExp;
		sumNext.sumMan = sumMan;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			sumValid <= 1'b0;
		end else begin
			sumValid <= alignValid;
		end
	end

	always_ff @(posedge clk) begin
		if (alignValid) begin
			sum <= sumNext;
		end
	end

	// Borrow would land in the carry bit
	aNoNegDiff: assert property (@(posedge clk) disable iff (!rstN)
		alignValid && align.ctrl == opSub |=> !sum.sumMan[manWidth+4])
		else $error("mantissa subtraction went negative");

endmodule

// File: hw/fpAddNormalize.sv
`timescale 1ns/100ps

module fpAddNormalize (
	input  logic            clk,
	input  logic            rstN,
	input  logic            sumValid,
	input  fpAddPkg::sumT   sum,
	output logic            normValid,
	output fpAddPkg::normT  norm
);

	import fpAddPkg::*;

	logic                carry;
	logic [3:0]          lzCount;      // 0 to 14
	logic [expWidth:0]   lzExt;
	logic [manWidth+3:0] leftMan;
	normT                normNext;

	assign carry = sum.sumMan[manWidth+4];

	// Highest set bit wins since the loop runs upward
	always_comb begin
		lzCount = 4'(manWidth + 4);                     // All zero
		for (int i = 0; i < manWidth + 4; i++) begin
			if (sum.sumMan[i]) begin
				lzCount = 4'(manWidth + 3 - i);
			end
		end
	end

	assign lzExt = {2'b00, lzCount};
	assign leftMan = sum.sumMan[manWidth+3:0] << lzCount;  // Hidden bit to the top

	always_comb begin
		normNext.zeroSum = sum.zeroSum;
		normNext.signA = sum.signA;
		normNext.signB = sum.signB;
		normNext.ctrl = sum.ctrl;
		normNext.maxAB = sum.maxAB;
		if (carry) begin
			// One step right, dropped bit joins sticky
			normNext.normM = sum.sumMan[manWidth+3:4];
			normNext.g = sum.sumMan[3];
			normNext.r = sum.sumMan[2];
			normNext.s = sum.sumMan[1] | sum.sumMan[0];
			normNext.normE = sum.bigExp + 1'b1;         // May reach 32
		end else begin
			normNext.normM = leftMan[manWidth+2:3];     // Hidden bit dropped
			normNext.g = leftMan[2];
			normNext.r = leftMan[1];
			normNext.s = leftMan[0];
			if (lzExt > sum.bigExp) begin
				normNext.normE = '0;                    // Clamp at zero
			end else begin
				normNext.normE = sum.bigExp - lzExt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			normValid <= 1'b0;
		end else begin
			normValid <= sumValid;
		end
	end

	always_ff @(posedge clk) begin
		if (sumValid) begin
			norm <= normNext;
		end
	end

endmodule

// File: hw/fpAddRound.sv
`timescale 1ns/100ps

module fpAddRound (
	input  logic            clk,
	input  logic            rstN,
	input  logic            normValid,
	input  fpAddPkg::normT  norm,
	output logic            outValid,
	output fpAddPkg::fpT    z,
	output logic            expOverflow  // Exponent reached 32
);

	import fpAddPkg::*;

	logic                 roundUp;
	logic [manWidth:0]    roundUpM;    // Spare bit for mantissa carry
	logic [manWidth-1:0]  roundM;
	logic                 roundOf;
	logic [expWidth:0]    roundE;
	logic                 fSign;
	logic [dataWidth-1:0] zNext;

	// Nearest even, a bare tie only rounds an odd LSB
	assign roundUp = norm.g & (norm.r | norm.s | norm.normM[0]);
	assign roundUpM = {1'b0, norm.normM} + 1'b1;
	assign roundM = roundUp ? roundUpM[manWidth-1:0] : norm.normM;
	assign roundOf = roundUp & roundUpM[manWidth];          // All ones wrapped to zero

	assign roundE = norm.zeroSum ? '0 : norm.normE + {{expWidth{1'b0}}, roundOf};

	// Exact zero is negative only for two negative addends
	assign fSign = norm.zeroSum ? (norm.signA & norm.signB & (norm.ctrl == opAdd))
		: (norm.maxAB ? norm.signB : norm.signA);            // Sign of larger magnitude

	assign zNext = {fSign, roundE[expWidth-1:0], roundM};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
			expOverflow <= 1'b0;
		end else begin
			outValid <= normValid;
			expOverflow <= normValid & roundE[expWidth];     // Top bit of wide exponent
		end
	end

	always_ff @(posedge clk) begin
		if (normValid) begin
			z <= fpT'(zNext);
		end
	end

	// Zero sum arrives with no mantissa bits left and never overflows
	aZeroNoOverflow: assert property (@(posedge clk) disable iff (!rstN)
		normValid && norm.zeroSum |=> !expOverflow && z.man == '0)
		else $error("zero sum gave a nonzero mantissa or an overflow");

endmodule

// File: hw/fpAddSub.sv
`timescale 1ns/100ps

module fpAddSub (
	input  logic          clk,
	input  logic          rstN,
	input  logic          inValid,      // One new operation per cycle at most
	input  fpAddPkg::fpT  a,
	input  fpAddPkg::fpT  b,
	input  fpAddPkg::opT  op,
	output logic          outValid,     // Four edges after inValid
	output fpAddPkg::fpT  z,
	output logic          expOverflow
);

	import fpAddPkg::*;

	logic  alignValid;
	alignT align;
	logic  sumValid;
	sumT   sum;
	logic  normValid;
	normT  norm;

	fpAddAlign uAlign (
		.clk        (clk),
		.rstN       (rstN),
		.inValid    (inValid),
		.a          (a),
		.b          (b),
		.op         (op),
		.alignValid (alignValid),
		.align      (align)
	);

	fpAddMantSum uMantSum (
		.clk        (clk),
		.rstN       (rstN),
		.alignValid (alignValid),
		.align      (align),
		.sumValid   (sumValid),
		.sum        (sum)
	);

	fpAddNormalize uNormalize (
		.clk       (clk),
		.rstN      (rstN),
		.sumValid  (sumValid),
		.sum       (sum),
		.normValid (normValid),
		.norm      (norm)
	);

	fpAddRound uRound (
		.clk         (clk),
		.rstN        (rstN),
		.normValid   (normValid),
		.norm        (norm),
		.outValid    (outValid),
		.z           (z),
		.expOverflow (expOverflow)
	);

endmodule

// File: dv/fpAddModel.svh
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

int unsigned lcgState = 32'd57479;  // Stream seed

// Full-period 32-bit LCG, upper half is the better-mixed part
function automatic logic [15:0] lcgNext16();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState[31:16];
endfunction

// Expected {overflow, result} for x op y, worked out in integers
function automatic logic [16:0] refAddSub(input logic [15:0] x, input logic [15:0] y,
	input logic sub);
	logic        signX;
	logic        signY;
	logic        bBigger;
	logic        sign;
	logic [14:0] bits;      // Carry, hidden bit, 10 bits, G/R/S
	logic [9:0]  man;
	logic        g;
	logic        r;
	logic        s;
	int          expX;
	int          expY;
	int          manX;
	int          manY;
	int          eBig;
	int          eSmall;
	int          mBig;
	int          mSmall;
	int          lz;
	int          e;
	longint      wide;
	longint      smallExt;
	longint      sumExt;

	signX = x[15];
	signY = y[15] ^ sub;                              // Subtraction negates y
	expX = int'(x[14:10]);
	expY = int'(y[14:10]);
	manX = (expX == 0) ? 0 : 1024 + int'(x[9:0]);    // Flush, else add hidden one
	manY = (expY == 0) ? 0 : 1024 + int'(y[9:0]);
	bBigger = (expY * 2048 + manY) > (expX * 2048 + manX);
	eBig = bBigger ? expY : expX;
	mBig = bBigger ? manY : manX;
	eSmall = bBigger ? expX : expY;
	mSmall = bBigger ? manX : manY;

	// Three fraction bits kept, everything further down only counts as sticky
	wide = (longint'(mSmall) << 40) >> (eBig - eSmall);
	smallExt = wide >> 37;
	if ((wide & 64'h1F_FFFF_FFFF) != 64'd0) begin
		smallExt = smallExt | 64'd1;
	end
	sumExt = longint'(mBig) << 3;
	sumExt = (signX != signY) ? sumExt - smallExt : sumExt + smallExt;

	if (sumExt == 64'd0) begin
		return {1'b0, signX & signY, 15'h0000};      // -0 only from two negatives
	end
	sign = bBigger ? signY : signX;
	bits = 15'(sumExt);
	if (bits[14]) begin
		e = eBig + 1;                                 // Sum reached 2.0
		man = bits[13:4];
		g = bits[3];
		r = bits[2];
		s = bits[1] | bits[0];
	end else begin
		lz = 0;
		while (!bits[13]) begin
			bits = bits << 1;
			lz++;
		end
		e = (lz > eBig) ? 0 : eBig - lz;             // No subnormal output
		man = bits[12:3];
		g = bits[2];
		r = bits[1];
		s = bits[0];
	end

	// Half an LSB or more, ties go to even
	if (g && (r || s || man[0])) begin
		if (man == 10'h3FF) begin
			e = e + 1;
		end
		man = man + 10'd1;
	end
	return {(e >= 32) ? 1'b1 : 1'b0, sign, 5'(e), man};
endfunction

`endif

// File: dv/fpAddSubTb.sv
`timescale 1ns/100ps

module fpAddSubTb;

	import fpAddPkg::*;

	`include "fpAddModel.svh"

	localparam int resetCycles = 5;
	localparam int streamOps = 300;
	localparam int timeoutCycles = 2000;   // 330 ops, drains and margin

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	fpT   a;
	fpT   b;
	opT   op;
	logic outValid;
	fpT   z;
	logic expOverflow;

	int          cycleCount = 0;
	int          sentCount = 0;
	int          doneCount = 0;
	string       testName = "reset";
	logic [16:0] expQ[$];                  // {overflow, z} per operation
	int          issueQ[$];               // Cycle that sampled inValid
	string       nameQ[$];

	fpAddSub dut (
		.clk         (clk),
		.rstN        (rstN),
		.inValid     (inValid),
		.a           (a),
		.b           (b),
		.op          (op),
		.outValid    (outValid),
		.z           (z),
		.expOverflow (expOverflow)
	);

	always #5 clk = ~clk;                  // 10 ns period

	task automatic stopOnError();
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			stopOnError();
		end
	endtask

	always @(posedge clk) begin
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, %0d results missing", cycleCount,
				sentCount - doneCount);
			stopOnError();
		end
	end

	// Scoreboard, sees the values from before the edge
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (rstN) begin
			if (inValid) begin
				expQ.push_back(refAddSub(a, b, op == opSub));
				issueQ.push_back(cycleCount);
				nameQ.push_back(testName);
			end
			if (outValid) begin
				if (expQ.size() == 0) begin
					$display("outValid asserted with no operation in flight");
					stopOnError();
				end else begin
					checkEq(nameQ[0], 32'(expQ[0]), 32'({expOverflow, z}));
					checkEq({nameQ[0], " latency"}, 32'(pipeDepth),
						32'(cycleCount - issueQ[0]));
					void'(expQ.pop_front());
					void'(issueQ.pop_front());
					void'(nameQ.pop_front());
					doneCount = doneCount + 1;
				end
			end
		end
	end

	task automatic sendOp(input fpT x, input fpT y, input opT o);
		@(posedge clk);
		a <= x;
		b <= y;
		op <= o;
		inValid <= 1'b1;
		sentCount++;
	endtask

	// Hand-worked value guards the model before the DUT sees the operands
	task automatic sendKnown(input fpT x, input fpT y, input opT o, input logic [16:0] handZ);
		checkEq({testName, " model"}, 32'(handZ), 32'(refAddSub(x, y, o == opSub)));
		sendOp(x, y, o);
	endtask

	task automatic drainPipe();
		@(posedge clk);
		inValid <= 1'b0;
		while (doneCount != sentCount) @(posedge clk);
	endtask

	task automatic testExactAdd();
		testName = "testExactAdd";
		sendKnown(16'h3C00, 16'h3C00, opAdd, 17'h04000);  // 1 + 1
		sendKnown(16'h4300, 16'h3D00, opSub, 17'h04080);  // 3.5 - 1.25
		sendKnown(16'h3C00, 16'hC000, opAdd, 17'h0BC00);  // 1 + -2
		sendKnown(16'hC300, 16'hBD00, opSub, 17'h0C080);  // -3.5 - -1.25
		sendKnown(16'h4000, 16'h4300, opSub, 17'h0BE00);  // b wins the sign
		sendKnown(16'h3800, 16'h3D00, opAdd, 17'h03F00);  // 0.5 + 1.25
		drainPipe();
	endtask

	task automatic testZeroSign();
		testName = "testZeroSign";
		sendKnown(16'h3D00, 16'h3D00, opSub, 17'h00000);
		sendKnown(16'hBD00, 16'h3D00, opAdd, 17'h00000);
		sendKnown(16'hC500, 16'hC500, opSub, 17'h00000);
		sendKnown(16'h8000, 16'h8000, opAdd, 17'h08000);  // Two negatives
		sendKnown(16'h8000, 16'h0000, opSub, 17'h08000);
		sendKnown(16'h0001, 16'h8001, opAdd, 17'h00000);  // Subnormals flushed
		drainPipe();
	endtask

	task automatic testRoundEven();
		testName = "testRoundEven";
		sendKnown(16'h3C00, 16'h1000, opAdd, 17'h03C00);  // Tie, already even
		sendKnown(16'h3C01, 16'h1000, opAdd, 17'h03C02);  // Tie, odd goes up
		sendKnown(16'h3C00, 16'h1001, opAdd, 17'h03C01);  // Sticky breaks the tie
		sendKnown(16'h3C00, 16'h0C00, opAdd, 17'h03C00);  // Quarter LSB dropped
		sendKnown(16'h3C00, 16'h1200, opAdd, 17'h03C01);
		sendKnown(16'h3C01, 16'h3C00, opAdd, 17'h04000);  // Carry shift, even tie
		sendKnown(16'h3C03, 16'h3C00, opAdd, 17'h04002);
		drainPipe();
	endtask

	task automatic testRoundCarry();
		testName = "testRoundCarry";
		sendKnown(16'h3FFF, 16'h1000, opAdd, 17'h04000);  // All ones wrap
		sendKnown(16'h7BFF, 16'h5000, opAdd, 17'h07C00);
		sendKnown(16'h3C01, 16'h3C00, opSub, 17'h01400);  // Near cancellation
		sendKnown(16'h3E00, 16'h3DFF, opSub, 17'h01400);
		sendKnown(16'h4000, 16'h3FFF, opSub, 17'h01400);
		sendKnown(16'h3C00, 16'h3BFF, opSub, 17'h01000);
		sendKnown(16'h0401, 16'h0400, opSub, 17'h00000);  // Exponent clamps at 0
		drainPipe();
	endtask

	task automatic testOverflow();
		testName = "testOverflow";
		sendKnown(16'h7FFF, 16'h5000, opAdd, 17'h10000);  // Rounding pushes to 32
		sendKnown(16'h7C00, 16'h7C00, opAdd, 17'h10000);
		sendKnown(16'hFFFF, 16'hFFFF, opAdd, 17'h183FF);
		sendKnown(16'h7FFF, 16'hFFFF, opSub, 17'h103FF);
		sendKnown(16'h7BFF, 16'h7BFF, opAdd, 17'h07FFF);  // Just below overflow
		sendKnown(16'h7800, 16'h7800, opAdd, 17'h07C00);  // Exp 31 is no overflow
		sendKnown(16'h7BFF, 16'h7BFF, opSub, 17'h00000);
		sendKnown(16'h3C00, 16'h3C00, opAdd, 17'h04000);
		drainPipe();
	endtask

	task automatic testStream();
		fpT          x;
		fpT          y;
		logic [15:0] pick;
		testName = "testStream";
		for (int i = 0; i < streamOps; i++) begin
			x = lcgNext16();
			y = lcgNext16();
			pick = lcgNext16();
			sendOp(x, y, pick[0] ? opSub : opAdd);  // One per cycle
		end
		drainPipe();
	endtask

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		a = '0;
		b = '0;
		op = opAdd;
		repeat (resetCycles) @(posedge clk);
		checkEq("reset outValid", 32'd0, 32'(outValid));
		checkEq("reset expOverflow", 32'd0, 32'(expOverflow));
		rstN <= 1'b1;
		testExactAdd();
		testZeroSign();
		testRoundEven();
		testRoundCarry();
		testOverflow();
		testStream();
		if (expQ.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("%0d results never came out", expQ.size());
			stopOnError();
		end
	end

endmodule

// File: filelist.f
hw/fpAddPkg.sv
hw/fpAddAlign.sv
hw/fpAddMantSum.sv
hw/fpAddNormalize.sv
hw/fpAddRound.sv
hw/fpAddSub.sv
+incdir+dv
dv/fpAddSubTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps -f filelist.f \
	--top-module fpAddSubTb -o fpAddSubSim || { echo "Build failed"; exit 1; }
simOut=$(./obj_dir/fpAddSubSim 2>&1)
echo "$simOut"
echo "$simOut" | grep -q "TEST PASSED" && exit 0 || exit 1
